/* tb.f */
source/line_buffer_pkg.sv
source/column_counter.sv
source/row_sequencer.sv
source/line_buffer_ctrl.sv
tests/line_buffer_ctrl_assertions.sv
tests/tb_line_buffer_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the line buffer controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_buffer_ctrl \
    -f tb.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"

/* tests/tb_line_buffer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_line_buffer_ctrl import line_buffer_pkg::*;;

    localparam int COL_W = DEFAULT_COL_W;
    localparam logic [COL_W-1:0] ROW_LEN = 6;
    localparam logic [COL_W-1:0] PAD_SHIFTS = 2;
    localparam logic [1:0] KIND_FIRST = 2'd0;
    localparam logic [1:0] KIND_MID = 2'd1;
    localparam logic [1:0] KIND_LAST = 2'd2;
    localparam int ROWS = 7;
    localparam int WATCHDOG_CYCLES = ROWS * (int'(ROW_LEN) + 4) * 8 + 50;

    logic clk;
    logic reset;
    logic first_row;
    logic mid_row;
    logic last_row;
    logic last_channel;
    logic [COL_W-1:0] image_size;
    logic s_axis_tvalid;
    logic m_axis_tready;
    logic s_axis_tready;
    logic bram_enable;
    logic bram_write;
    logic [COL_W-1:0] bram_addr;
    logic window_shift;
    logic sel_row_n2;
    logic sel_row_n1;
    logic sel_row_n;
    logic output_valid;
    logic done_row;

    // Reference model state
    logic [1:0] row_kind;
    logic in_row;
    logic lc_expected;
    logic reset_q;
    logic [COL_W-1:0] beat_cnt;
    logic [COL_W-1:0] shift_cnt;
    logic [COL_W-1:0] valid_cnt;
    int error_count;
    int bound_errors;
    int rows_done;

    line_buffer_ctrl line_buffer_ctrl_inst (.*);

    always #20 clk = ~clk;

    function automatic logic [COL_W-1:0] beats_per_row(input logic [1:0] kind);
        return (kind == KIND_LAST) ? '0 : ROW_LEN;
    endfunction

    function automatic logic [COL_W-1:0] shifts_per_row(input logic [1:0] kind);
        return (kind == KIND_FIRST) ? ROW_LEN : ROW_LEN + PAD_SHIFTS;
    endfunction

    function automatic logic [COL_W-1:0] valids_per_row(input logic [1:0] kind);
        return (kind == KIND_FIRST) ? '0 : ROW_LEN;
    endfunction

    // Pad and trailing shifts of mid and last rows carry no row select
    function automatic logic selected_on_shift(input logic [1:0] kind,
                                               input logic [COL_W-1:0] shifts);
        return (kind == KIND_FIRST) || (shifts != '0 && shifts <= ROW_LEN);
    endfunction

    function automatic void log_mismatch(input string text);
        error_count++;
        $display("FAILED %s", text);
    endfunction

    // Row tracking and per-row counts from the DUT ports
    always @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            in_row    <= 1'b0;
            beat_cnt  <= '0;
            shift_cnt <= '0;
            valid_cnt <= '0;
        end else if (first_row || mid_row || last_row) begin
            in_row    <= 1'b1;
            beat_cnt  <= '0;
            shift_cnt <= '0;
            valid_cnt <= '0;
        end else begin
            if (done_row) begin
                in_row <= 1'b0;
            end
            if (s_axis_tvalid && s_axis_tready) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (window_shift) begin
                shift_cnt <= shift_cnt + 1'b1;
            end
            if (output_valid) begin
                valid_cnt <= valid_cnt + 1'b1;
            end
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (reset)
        !in_row |-> !s_axis_tready && !bram_write && !window_shift && !output_valid && !done_row)
    else log_mismatch($sformatf(
        "idle: s_axis_tready=%h bram_write=%h window_shift=%h output_valid=%h done_row=%h",
        s_axis_tready, bram_write, window_shift, output_valid, done_row));

    enable_on: assert property (@(posedge clk) disable iff (reset) !reset_q |-> bram_enable)
    else log_mismatch($sformatf("bram_enable=%h expected 1", bram_enable));

    first_writes: assert property (@(posedge clk) disable iff (reset)
        in_row && row_kind == KIND_FIRST |-> bram_write == (s_axis_tvalid && s_axis_tready)
            && window_shift == bram_write && !output_valid)
    else log_mismatch($sformatf("first row: bram_write=%h window_shift=%h output_valid=%h",
        bram_write, window_shift, output_valid));

    write_addr: assert property (@(posedge clk) disable iff (reset)
        bram_write |-> bram_addr == beat_cnt)
    else log_mismatch($sformatf("bram_addr=%h expected %h", bram_addr, beat_cnt));

    mid_stall: assert property (@(posedge clk) disable iff (reset)
        in_row && row_kind == KIND_MID && sel_row_n && !s_axis_tvalid |-> !output_valid)
    else log_mismatch($sformatf("mid stall: output_valid=%h expected 0", output_valid));

    last_read_only: assert property (@(posedge clk) disable iff (reset)
        in_row && row_kind == KIND_LAST |-> !s_axis_tready && !bram_write && !sel_row_n)
    else log_mismatch($sformatf("last row: s_axis_tready=%h bram_write=%h sel_row_n=%h",
        s_axis_tready, bram_write, sel_row_n));

    select_pattern: assert property (@(posedge clk) disable iff (reset)
        in_row |-> ((row_kind == KIND_FIRST) ? (!sel_row_n2 && !sel_row_n1)
            : (row_kind == KIND_MID) ? (sel_row_n2 == sel_row_n && sel_row_n1 == sel_row_n)
            : (sel_row_n2 == sel_row_n1)))
    else log_mismatch($sformatf("selects: sel_row_n2=%h sel_row_n1=%h sel_row_n=%h",
        sel_row_n2, sel_row_n1, sel_row_n));

    select_timing: assert property (@(posedge clk) disable iff (reset)
        in_row && window_shift |-> ((row_kind == KIND_LAST) ? sel_row_n1 : sel_row_n)
            == selected_on_shift(row_kind, shift_cnt))
    else log_mismatch($sformatf("select on shift: shift_cnt=%h sel_row_n1=%h sel_row_n=%h",
        shift_cnt, sel_row_n1, sel_row_n));

    downstream_hold: assert property (@(posedge clk) disable iff (reset)
        lc_expected && !m_axis_tready |-> !s_axis_tready && !window_shift && !bram_write)
    else log_mismatch($sformatf("hold: s_axis_tready=%h window_shift=%h bram_write=%h",
        s_axis_tready, window_shift, bram_write));

    row_totals: assert property (@(posedge clk) disable iff (reset)
        done_row |=> beat_cnt == beats_per_row(row_kind)
            && shift_cnt == shifts_per_row(row_kind)
            && valid_cnt == valids_per_row(row_kind))
    else log_mismatch($sformatf("totals: beat_cnt=%h shift_cnt=%h valid_cnt=%h",
        beat_cnt, shift_cnt, valid_cnt));

    task automatic drive_stream();
        s_axis_tvalid = ($urandom_range(0, 3) != 0);
        if (lc_expected) begin
            m_axis_tready = ($urandom_range(0, 2) != 0);
        end
    endtask

    task automatic run_row(input logic [1:0] kind);
        logic finished;
        finished = 1'b0;
        @(negedge clk);
        row_kind  = kind;
        first_row = (kind == KIND_FIRST);
        mid_row   = (kind == KIND_MID);
        last_row  = (kind == KIND_LAST);
        @(negedge clk);
        first_row = 1'b0;
        mid_row   = 1'b0;
        last_row  = 1'b0;
        while (!finished) begin
            drive_stream();
            @(negedge clk);
            finished = done_row;
        end
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        repeat (2) @(negedge clk);
        rows_done++;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: rows did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        first_row = 1'b0;
        mid_row = 1'b0;
        last_row = 1'b0;
        last_channel = 1'b0;
        image_size = ROW_LEN;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b1;
        row_kind = KIND_FIRST;
        lc_expected = 1'b0;
        reset_q = 1'b1;
        error_count = 0;
        bound_errors = 0;
        rows_done = 0;
        void'($urandom(32'h61b9_e9fc));
        repeat (3) @(negedge clk);
        reset = 1'b0;
        // Source already offering data while idle
        s_axis_tvalid = 1'b1;
        repeat (3) @(negedge clk);
        s_axis_tvalid = 1'b0;

        run_row(KIND_FIRST);
        run_row(KIND_MID);
        run_row(KIND_MID);
        run_row(KIND_LAST);

        last_channel = 1'b1;
        repeat (2) @(negedge clk);
        lc_expected = 1'b1;

        run_row(KIND_FIRST);
        run_row(KIND_MID);
        run_row(KIND_LAST);
        repeat (3) @(negedge clk);

        bound_errors = line_buffer_ctrl_inst.line_buffer_ctrl_assertions_inst.fail_count;
        $display("Rows completed %0d of %0d, testbench errors %0d, bound assertion errors %0d",
            rows_done, ROWS, error_count, bound_errors);
        if (error_count == 0 && bound_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/line_buffer_ctrl_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module line_buffer_ctrl_assertions (
    input wire clk,
    input wire reset,
    input wire first_row,
    input wire mid_row,
    input wire last_row,
    input wire last_channel,
    input wire s_axis_tvalid,
    input wire m_axis_tready,
    input wire s_axis_tready,
    input wire bram_write,
    input wire window_shift,
    input wire output_valid,
    input wire done_row
);

    logic busy;
    logic lc_mode;
    logic command;
    int   fail_count = 0;

    assign command = first_row || mid_row || last_row;

    // Row in progress from command to done_row
    always @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            lc_mode <= 1'b0;
        end else begin
            busy <= busy ? !done_row : command;
            if (!busy && !command && last_channel) begin
                lc_mode <= 1'b1;
            end
        end
    end

    beat_written: assert property (@(posedge clk) disable iff (reset)
        s_axis_tvalid && s_axis_tready |-> bram_write)
    else begin
        fail_count++;
        $error("accepted beat without a BRAM write");
    end

    lc_hold: assert property (@(posedge clk) disable iff (reset)
        lc_mode && !m_axis_tready |-> !s_axis_tready && !window_shift && !bram_write)
    else begin
        fail_count++;
        $error("row advanced while downstream was not ready");
    end

    no_row_activity: assert property (@(posedge clk) disable iff (reset)
        !busy |-> !done_row && !output_valid)
    else begin
        fail_count++;
        $error("done_row or output_valid outside a row");
    end

    done_single: assert property (@(posedge clk) disable iff (reset)
        done_row |=> !done_row)
    else begin
        fail_count++;
        $error("done_row high on two consecutive cycles");
    end

endmodule

bind line_buffer_ctrl line_buffer_ctrl_assertions line_buffer_ctrl_assertions_inst (.*);

`default_nettype wire

/* source/line_buffer_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module line_buffer_ctrl import line_buffer_pkg::*; #(
    parameter int COL_W = DEFAULT_COL_W
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              first_row,
    input  wire              mid_row,
    input  wire              last_row,
    input  wire              last_channel,
    input  wire [COL_W-1:0]  image_size,
    input  wire              s_axis_tvalid,
    input  wire              m_axis_tready,
    output logic             s_axis_tready,
    output logic             bram_enable,
    output logic             bram_write,
    output logic [COL_W-1:0] bram_addr,
    output logic             window_shift,
    output logic             sel_row_n2,
    output logic             sel_row_n1,
    output logic             sel_row_n,
    output logic             output_valid,
    output logic             done_row
);

    logic count_en;
    logic count_clear;
    logic row_end;
    logic window_full;

    row_sequencer row_sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .first_row     (first_row),
        .mid_row       (mid_row),
        .last_row      (last_row),
        .last_channel  (last_channel),
        .s_axis_tvalid (s_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .row_end       (row_end),
        .window_full   (window_full),
        .s_axis_tready (s_axis_tready),
        .bram_enable   (bram_enable),
        .bram_write    (bram_write),
        .window_shift  (window_shift),
        .sel_row_n2    (sel_row_n2),
        .sel_row_n1    (sel_row_n1),
        .sel_row_n     (sel_row_n),
        .output_valid  (output_valid),
        .done_row      (done_row),
        .count_en      (count_en),
        .count_clear   (count_clear)
    );

    // Column index drives the BRAM address directly
    column_counter #(
        .COL_W (COL_W)
    ) column_counter_inst (
        .clk         (clk),
        .reset       (reset),
        .count_en    (count_en),
        .count_clear (count_clear),
        .image_size  (image_size),
        .col         (bram_addr),
        .row_end     (row_end),
        .window_full (window_full)
    );

endmodule

`default_nettype wire

/* source/row_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module row_sequencer import line_buffer_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    input  wire  first_row,
    input  wire  mid_row,
    input  wire  last_row,
    input  wire  last_channel,
    input  wire  s_axis_tvalid,
    input  wire  m_axis_tready,
    input  wire  row_end,
    input  wire  window_full,
    output logic s_axis_tready,
    output logic bram_enable,
    output logic bram_write,
    output logic window_shift,
    output logic sel_row_n2,
    output logic sel_row_n1,
    output logic sel_row_n,
    output logic output_valid,
    output logic done_row,
    output logic count_en,
    output logic count_clear
);

    logic [STATE_W-1:0] state;
    logic [STATE_W-1:0] next_state;
    logic               lc_mode;
    logic               down_ready;
    logic               stream_adv;

    // In last-channel mode every column waits on the consumer
    assign down_ready = !lc_mode || m_axis_tready;
    assign stream_adv = s_axis_tvalid && down_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            lc_mode <= 1'b0;
        end else if (state == ST_IDLE && !first_row && !mid_row && !last_row && last_channel) begin
            lc_mode <= 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET: next_state = ST_IDLE;
            ST_IDLE: begin
                if (first_row) begin
                    next_state = ST_FIRST_WAIT;
                end else if (mid_row) begin
                    next_state = ST_MID_PAD;
                end else if (last_row) begin
                    next_state = ST_LAST_PAD;
                end
            end
            ST_FIRST_WAIT: begin
                if (stream_adv) begin
                    next_state = ST_FIRST_STREAM;
                end
            end
            ST_FIRST_STREAM: begin
                if (row_end) begin
                    next_state = ST_IDLE;
                end else if (!stream_adv) begin
                    next_state = ST_FIRST_WAIT;
                end
            end
            ST_MID_PAD: begin
                if (down_ready) begin
                    next_state = ST_MID_WAIT;
                end
            end
            ST_MID_WAIT: begin
                if (stream_adv) begin
                    next_state = ST_MID_STREAM;
                end
            end
            ST_MID_STREAM: begin
                if (row_end) begin
                    if (down_ready) begin
                        next_state = ST_FINISH;
                    end
                end else if (!stream_adv) begin
                    next_state = ST_MID_WAIT;
                end
            end
            ST_FINISH: next_state = ST_IDLE;
            ST_LAST_PAD: begin
                if (down_ready) begin
                    next_state = ST_LAST_STREAM;
                end
            end
            // Also the last-row stall while down_ready is low
            ST_LAST_STREAM: begin
                if (row_end && down_ready) begin
                    next_state = ST_FINISH;
                end
            end
            default: next_state = ST_RESET;
        endcase
    end

    always_comb begin
        s_axis_tready = 1'b0;
        bram_enable   = (state != ST_RESET);
        bram_write    = 1'b0;
        window_shift  = 1'b0;
        sel_row_n2    = 1'b0;
        sel_row_n1    = 1'b0;
        sel_row_n     = 1'b0;
        output_valid  = 1'b0;
        done_row      = 1'b0;
        count_en      = 1'b0;
        count_clear   = 1'b0;

        case (state)
            ST_IDLE: count_clear = 1'b1;
            ST_FIRST_WAIT, ST_FIRST_STREAM: begin
                if (state == ST_FIRST_STREAM && row_end) begin
                    done_row    = 1'b1;
                    count_clear = 1'b1;
                end else begin
                    sel_row_n     = 1'b1;
                    s_axis_tready = down_ready;
                    bram_write    = stream_adv;
                    window_shift  = stream_adv;
                    count_en      = stream_adv;
                end
            end
            ST_MID_PAD, ST_LAST_PAD: window_shift = down_ready;
            ST_MID_WAIT, ST_MID_STREAM: begin
                if (state == ST_MID_STREAM && row_end) begin
                    // Trailing pad shift
                    window_shift = down_ready;
                    output_valid = down_ready;
                    count_clear  = down_ready;
                end else begin
                    sel_row_n2    = 1'b1;
                    sel_row_n1    = 1'b1;
                    sel_row_n     = 1'b1;
                    s_axis_tready = down_ready;
                    bram_write    = stream_adv;
                    window_shift  = stream_adv;
                    count_en      = stream_adv;
                    output_valid  = stream_adv && window_full;
                end
            end
            ST_LAST_STREAM: begin
                window_shift = down_ready;
                if (row_end) begin
                    output_valid = down_ready;
                    count_clear  = down_ready;
                end else begin
                    sel_row_n2   = 1'b1;
                    sel_row_n1   = 1'b1;
                    count_en     = down_ready;
                    output_valid = down_ready && window_full;
                end
            end
            ST_FINISH: begin
                done_row     = 1'b1;
                output_valid = 1'b1;
            end
            default: begin
                bram_enable = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/column_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module column_counter import line_buffer_pkg::*; #(
    parameter int COL_W = DEFAULT_COL_W
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              count_en,
    input  wire              count_clear,
    input  wire [COL_W-1:0]  image_size,
    output logic [COL_W-1:0] col,
    output logic             row_end,
    output logic             window_full
);

    localparam logic [COL_W-1:0] VALID_COL = COL_W'(VALID_START_COL);

    // Column index that doubles as the BRAM address
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
        end else if (count_clear) begin
            col <= '0;
        end else if (count_en) begin
            col <= col + 1'b1;
        end
    end

    // All image_size columns consumed
    always_comb begin
        row_end = (col == image_size);
    end

    // Two columns already in the window
    always_comb begin
        window_full = (col >= VALID_COL);
    end

endmodule

`default_nettype wire

/* source/line_buffer_pkg.sv */
`default_nettype none

package line_buffer_pkg;

    // Row machine state encoding
    localparam int STATE_W = 4;

    localparam logic [STATE_W-1:0] ST_RESET        = 4'd0;
    localparam logic [STATE_W-1:0] ST_IDLE         = 4'd1;

    // First row fills the line buffer only
    localparam logic [STATE_W-1:0] ST_FIRST_WAIT   = 4'd2;
    localparam logic [STATE_W-1:0] ST_FIRST_STREAM = 4'd3;

    // Mid row with leading pad then stream
    localparam logic [STATE_W-1:0] ST_MID_PAD      = 4'd4;
    localparam logic [STATE_W-1:0] ST_MID_WAIT     = 4'd5;
    localparam logic [STATE_W-1:0] ST_MID_STREAM   = 4'd6;

    // Shared by mid and last rows
    localparam logic [STATE_W-1:0] ST_FINISH       = 4'd7;

    // Last row reads the buffer only
    localparam logic [STATE_W-1:0] ST_LAST_PAD     = 4'd8;
    localparam logic [STATE_W-1:0] ST_LAST_STREAM  = 4'd9;

    // Column counter width unless overridden at the top
    localparam int DEFAULT_COL_W = 8;

    // First column holding a complete 3x3 window
    localparam int VALID_START_COL = 2;

endpackage

`default_nettype wire
